// File: rtl/axi_pkg.sv
/*
 * AXI protocol types
 * Burst, response, length and size encodings plus the beat address rule
 * used by the write and read engines.
 */
`default_nettype none

package axi_pkg;

  // Widest address the beat address rule handles
  localparam int unsigned MaxAddrWidth = 64;

  typedef logic [MaxAddrWidth-1:0] axi_addr_t;

  // Burst length minus one
  typedef logic [7:0] len_t;

  // Bytes per beat as a power of two
  typedef logic [2:0] size_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Byte address of beat number count within a burst.
  // WRAP takes the INCR path, both engines reject it anyway
  function automatic axi_addr_t beat_addr(axi_addr_t base, size_t size, burst_e burst,
                                          len_t count);
    axi_addr_t bytes;
    axi_addr_t aligned;
    bytes   = axi_addr_t'(1) << size;
    aligned = base & ~(bytes - axi_addr_t'(1));
    if (burst == FIXED || count == '0) begin
      return base;
    end
    // First beat may be unaligned, the rest start on size boundaries
    return aligned + (axi_addr_t'(count) << size);
  endfunction

endpackage

`default_nettype wire

// File: rtl/mem_ctrl_pkg.sv
/*
 * Controller states
 * FSM encodings of the write and read engines of the AXI memory.
 */
`default_nettype none

package mem_ctrl_pkg;

  // AW accept, W beats, B response
  typedef enum logic [1:0] {
    WR_IDLE = 2'b00,
    WR_DATA = 2'b01,
    WR_RESP = 2'b10
  } wr_state_e;

  // AR accept, array read, R beat
  typedef enum logic [1:0] {
    RD_IDLE  = 2'b00,
    RD_FETCH = 2'b01,
    RD_DATA  = 2'b10
  } rd_state_e;

endpackage

`default_nettype wire

// File: rtl/mem_byte_array.sv
/*
 * Byte-strobed word memory
 * One write port with per-byte enables and one registered read port.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_byte_array #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned MemBytes  = 1024,
  localparam int unsigned StrbWidth = DataWidth / 8,
  localparam int unsigned Words     = MemBytes / StrbWidth,
  localparam int unsigned IdxWidth  = $clog2(Words)
) (
  input  logic                 clk_i,
  input  logic                 wr_en_i,
  input  logic [IdxWidth-1:0]  wr_index_i,
  input  logic [DataWidth-1:0] wr_data_i,
  input  logic [StrbWidth-1:0] wr_strb_i,
  input  logic                 rd_en_i,
  input  logic [IdxWidth-1:0]  rd_index_i,
  output logic [DataWidth-1:0] rd_data_o
);

  logic [DataWidth-1:0] mem_q [Words];

  // Only strobed lanes are updated
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (wr_strb_i[b]) begin
          mem_q[wr_index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  // Returns old contents on a same-edge write
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_wr_ctrl.sv
/*
 * AXI write engine
 * Accepts one AW burst at a time, writes W beats into the array,
 * returns the B response and reports each beat on the write monitor.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_wr_ctrl #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned MemBytes  = 1024,
  localparam int unsigned StrbWidth = DataWidth / 8,
  localparam int unsigned IdxWidth  = $clog2(MemBytes / StrbWidth)
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  logic [IdWidth-1:0]    aw_id_i,
  input  logic [AddrWidth-1:0]  aw_addr_i,
  input  axi_pkg::len_t         aw_len_i,
  input  axi_pkg::size_t        aw_size_i,
  input  axi_pkg::burst_e       aw_burst_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  logic [DataWidth-1:0]  w_data_i,
  input  logic [StrbWidth-1:0]  w_strb_i,
  input  logic                  w_last_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic [IdWidth-1:0]    b_id_o,
  output axi_pkg::resp_e        b_resp_o,
  output logic                  wr_en_o,
  output logic [IdxWidth-1:0]   wr_index_o,
  output logic [DataWidth-1:0]  wr_data_o,
  output logic [StrbWidth-1:0]  wr_strb_o,
  output logic                  mon_w_valid_o,
  output logic [AddrWidth-1:0]  mon_w_addr_o,
  output logic [DataWidth-1:0]  mon_w_data_o,
  output logic [IdWidth-1:0]    mon_w_id_o,
  output axi_pkg::len_t         mon_w_beat_count_o,
  output logic                  mon_w_last_o
);

  import axi_pkg::*;
  import mem_ctrl_pkg::*;

  localparam int unsigned OffWidth = $clog2(StrbWidth);
  localparam logic [AddrWidth:0] MemLimit = (AddrWidth + 1)'(MemBytes);

  wr_state_e            state_q;
  wr_state_e            state_d;
  logic [IdWidth-1:0]   id_q;
  logic [AddrWidth-1:0] addr_q;
  len_t                 len_q;
  size_t                size_q;
  burst_e               burst_q;
  len_t                 cnt_q;
  logic                 err_q;
  axi_addr_t            beat_full;
  logic [AddrWidth-1:0] beat_addr_w;
  logic                 aw_hs;
  logic                 w_hs;
  logic                 b_hs;
  logic                 last_beat;
  logic                 beat_ok;

  assign aw_hs = aw_valid_i & aw_ready_o;
  assign w_hs  = w_valid_i & w_ready_o;
  assign b_hs  = b_valid_o & b_ready_i;

  // Burst end comes from the beat counter alone
  assign last_beat = (cnt_q == len_q);

  assign beat_full   = beat_addr(axi_addr_t'(addr_q), size_q, burst_q, cnt_q);
  assign beat_addr_w = beat_full[AddrWidth-1:0];
  assign beat_ok     = ({1'b0, beat_addr_w} < MemLimit) && (burst_q != WRAP);

  // Array write happens on the W transfer edge itself
  assign wr_en_o    = w_hs & beat_ok;
  assign wr_index_o = beat_addr_w[OffWidth +: IdxWidth];
  assign wr_data_o  = w_data_i;
  assign wr_strb_o  = w_strb_i;
  assign b_id_o     = id_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WR_IDLE: if (aw_hs) state_d = WR_DATA;
      WR_DATA: if (w_hs && last_beat) state_d = WR_RESP;
      WR_RESP: if (b_hs) state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= WR_IDLE;
      aw_ready_o    <= 1'b0;
      w_ready_o     <= 1'b0;
      b_valid_o     <= 1'b0;
      cnt_q         <= '0;
      err_q         <= 1'b0;
      mon_w_valid_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      aw_ready_o    <= (state_d == WR_IDLE);
      w_ready_o     <= (state_d == WR_DATA);
      b_valid_o     <= (state_d == WR_RESP);
      mon_w_valid_o <= w_hs;
      if (aw_hs) begin
        cnt_q <= '0;
        err_q <= 1'b0;
      end else if (w_hs) begin
        cnt_q <= cnt_q + len_t'(1);
        // Sticky over the burst
        if (!beat_ok) err_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q    <= aw_id_i;
      addr_q  <= aw_addr_i;
      len_q   <= aw_len_i;
      size_q  <= aw_size_i;
      burst_q <= aw_burst_i;
    end
    if (w_hs && last_beat) begin
      if (err_q || !beat_ok) begin
        b_resp_o <= SLVERR;
      end else begin
        b_resp_o <= OKAY;
      end
    end
  end

  // Monitor payload trails the W transfer by one cycle
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      mon_w_addr_o       <= beat_addr_w;
      mon_w_data_o       <= w_data_i;
      mon_w_id_o         <= id_q;
      mon_w_beat_count_o <= cnt_q;
      mon_w_last_o       <= last_beat;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_rd_ctrl.sv
/*
 * AXI read engine
 * Accepts one AR burst at a time, fetches each beat from the array,
 * returns R beats and reports each delivered beat on the read monitor.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_rd_ctrl #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned MemBytes  = 1024,
  localparam int unsigned StrbWidth = DataWidth / 8,
  localparam int unsigned IdxWidth  = $clog2(MemBytes / StrbWidth)
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  logic [IdWidth-1:0]    ar_id_i,
  input  logic [AddrWidth-1:0]  ar_addr_i,
  input  axi_pkg::len_t         ar_len_i,
  input  axi_pkg::size_t        ar_size_i,
  input  axi_pkg::burst_e       ar_burst_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output logic [IdWidth-1:0]    r_id_o,
  output logic [DataWidth-1:0]  r_data_o,
  output axi_pkg::resp_e        r_resp_o,
  output logic                  r_last_o,
  output logic                  rd_en_o,
  output logic [IdxWidth-1:0]   rd_index_o,
  input  logic [DataWidth-1:0]  rd_data_i,
  output logic                  mon_r_valid_o,
  output logic [AddrWidth-1:0]  mon_r_addr_o,
  output logic [DataWidth-1:0]  mon_r_data_o,
  output logic [IdWidth-1:0]    mon_r_id_o,
  output axi_pkg::len_t         mon_r_beat_count_o,
  output logic                  mon_r_last_o
);

  import axi_pkg::*;
  import mem_ctrl_pkg::*;

  localparam int unsigned OffWidth = $clog2(StrbWidth);
  localparam logic [AddrWidth:0] MemLimit = (AddrWidth + 1)'(MemBytes);

  rd_state_e            state_q;
  rd_state_e            state_d;
  logic [IdWidth-1:0]   id_q;
  logic [AddrWidth-1:0] addr_q;
  len_t                 len_q;
  size_t                size_q;
  burst_e               burst_q;
  len_t                 cnt_q;
  axi_addr_t            beat_full;
  logic [AddrWidth-1:0] beat_addr_w;
  logic                 ar_hs;
  logic                 r_hs;
  logic                 last_beat;
  logic                 beat_ok;

  assign ar_hs     = ar_valid_i & ar_ready_o;
  assign r_hs      = r_valid_o & r_ready_i;
  assign last_beat = (cnt_q == len_q);

  // Counter is stable from fetch until the R transfer
  assign beat_full   = beat_addr(axi_addr_t'(addr_q), size_q, burst_q, cnt_q);
  assign beat_addr_w = beat_full[AddrWidth-1:0];
  assign beat_ok     = ({1'b0, beat_addr_w} < MemLimit) && (burst_q != WRAP);

  assign rd_en_o    = (state_q == RD_FETCH) & beat_ok;
  assign rd_index_o = beat_addr_w[OffWidth +: IdxWidth];

  // Rejected beats carry zero data
  assign r_data_o = beat_ok ? rd_data_i : '0;
  assign r_id_o   = id_q;
  assign r_last_o = last_beat;

  always_comb begin
    if (beat_ok) begin
      r_resp_o = OKAY;
    end else begin
      r_resp_o = SLVERR;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RD_IDLE:  if (ar_hs) state_d = RD_FETCH;
      RD_FETCH: state_d = RD_DATA;
      RD_DATA: begin
        if (r_hs) begin
          if (last_beat) begin
            state_d = RD_IDLE;
          end else begin
            state_d = RD_FETCH;
          end
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= RD_IDLE;
      ar_ready_o    <= 1'b0;
      r_valid_o     <= 1'b0;
      cnt_q         <= '0;
      mon_r_valid_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      ar_ready_o    <= (state_d == RD_IDLE);
      r_valid_o     <= (state_d == RD_DATA);
      mon_r_valid_o <= r_hs;
      if (ar_hs) begin
        cnt_q <= '0;
      end else if (r_hs) begin
        cnt_q <= cnt_q + len_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q    <= ar_id_i;
      addr_q  <= ar_addr_i;
      len_q   <= ar_len_i;
      size_q  <= ar_size_i;
      burst_q <= ar_burst_i;
    end
  end

  // Delivered beat shows up on the monitor one cycle later
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      mon_r_addr_o       <= beat_addr_w;
      mon_r_data_o       <= r_data_o;
      mon_r_id_o         <= id_q;
      mon_r_beat_count_o <= cnt_q;
      mon_r_last_o       <= last_beat;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_top.sv
/*
 * AXI4 slave memory
 * Write and read engines sharing one byte-strobed array, with a
 * beat monitor per direction.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned MemBytes  = 1024
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  logic [IdWidth-1:0]       aw_id_i,
  input  logic [AddrWidth-1:0]     aw_addr_i,
  input  axi_pkg::len_t            aw_len_i,
  input  axi_pkg::size_t           aw_size_i,
  input  axi_pkg::burst_e          aw_burst_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  input  logic [DataWidth-1:0]     w_data_i,
  input  logic [DataWidth/8-1:0]   w_strb_i,
  input  logic                     w_last_i,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output logic [IdWidth-1:0]       b_id_o,
  output axi_pkg::resp_e           b_resp_o,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  logic [IdWidth-1:0]       ar_id_i,
  input  logic [AddrWidth-1:0]     ar_addr_i,
  input  axi_pkg::len_t            ar_len_i,
  input  axi_pkg::size_t           ar_size_i,
  input  axi_pkg::burst_e          ar_burst_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output logic [IdWidth-1:0]       r_id_o,
  output logic [DataWidth-1:0]     r_data_o,
  output axi_pkg::resp_e           r_resp_o,
  output logic                     r_last_o,
  output logic                     mon_w_valid_o,
  output logic [AddrWidth-1:0]     mon_w_addr_o,
  output logic [DataWidth-1:0]     mon_w_data_o,
  output logic [IdWidth-1:0]       mon_w_id_o,
  output axi_pkg::len_t            mon_w_beat_count_o,
  output logic                     mon_w_last_o,
  output logic                     mon_r_valid_o,
  output logic [AddrWidth-1:0]     mon_r_addr_o,
  output logic [DataWidth-1:0]     mon_r_data_o,
  output logic [IdWidth-1:0]       mon_r_id_o,
  output axi_pkg::len_t            mon_r_beat_count_o,
  output logic                     mon_r_last_o
);

  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdxWidth  = $clog2(MemBytes / StrbWidth);

  logic                 wr_en;
  logic [IdxWidth-1:0]  wr_index;
  logic [DataWidth-1:0] wr_data;
  logic [StrbWidth-1:0] wr_strb;
  logic                 rd_en;
  logic [IdxWidth-1:0]  rd_index;
  logic [DataWidth-1:0] rd_data;

  axi_mem_wr_ctrl #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .IdWidth   (IdWidth),
    .MemBytes  (MemBytes)
  ) u_wr_ctrl (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .aw_valid_i         (aw_valid_i),
    .aw_ready_o         (aw_ready_o),
    .aw_id_i            (aw_id_i),
    .aw_addr_i          (aw_addr_i),
    .aw_len_i           (aw_len_i),
    .aw_size_i          (aw_size_i),
    .aw_burst_i         (aw_burst_i),
    .w_valid_i          (w_valid_i),
    .w_ready_o          (w_ready_o),
    .w_data_i           (w_data_i),
    .w_strb_i           (w_strb_i),
    .w_last_i           (w_last_i),
    .b_valid_o          (b_valid_o),
    .b_ready_i          (b_ready_i),
    .b_id_o             (b_id_o),
    .b_resp_o           (b_resp_o),
    .wr_en_o            (wr_en),
    .wr_index_o         (wr_index),
    .wr_data_o          (wr_data),
    .wr_strb_o          (wr_strb),
    .mon_w_valid_o      (mon_w_valid_o),
    .mon_w_addr_o       (mon_w_addr_o),
    .mon_w_data_o       (mon_w_data_o),
    .mon_w_id_o         (mon_w_id_o),
    .mon_w_beat_count_o (mon_w_beat_count_o),
    .mon_w_last_o       (mon_w_last_o)
  );

  axi_mem_rd_ctrl #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .IdWidth   (IdWidth),
    .MemBytes  (MemBytes)
  ) u_rd_ctrl (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .ar_valid_i         (ar_valid_i),
    .ar_ready_o         (ar_ready_o),
    .ar_id_i            (ar_id_i),
    .ar_addr_i          (ar_addr_i),
    .ar_len_i           (ar_len_i),
    .ar_size_i          (ar_size_i),
    .ar_burst_i         (ar_burst_i),
    .r_valid_o          (r_valid_o),
    .r_ready_i          (r_ready_i),
    .r_id_o             (r_id_o),
    .r_data_o           (r_data_o),
    .r_resp_o           (r_resp_o),
    .r_last_o           (r_last_o),
    .rd_en_o            (rd_en),
    .rd_index_o         (rd_index),
    .rd_data_i          (rd_data),
    .mon_r_valid_o      (mon_r_valid_o),
    .mon_r_addr_o       (mon_r_addr_o),
    .mon_r_data_o       (mon_r_data_o),
    .mon_r_id_o         (mon_r_id_o),
    .mon_r_beat_count_o (mon_r_beat_count_o),
    .mon_r_last_o       (mon_r_last_o)
  );

  mem_byte_array #(
    .DataWidth (DataWidth),
    .MemBytes  (MemBytes)
  ) u_array (
    .clk_i      (clk_i),
    .wr_en_i    (wr_en),
    .wr_index_i (wr_index),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .rd_en_i    (rd_en),
    .rd_index_i (rd_index),
    .rd_data_o  (rd_data)
  );

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.svh
/*
 * Reference memory for the AXI memory testbench
 * Byte array plus the expected beat address, data and response rules.
 */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

logic [7:0] model_mem [MemBytes];

// FIXED keeps the base, INCR aligns to the size and steps by the size
function automatic int unsigned expected_addr(int unsigned base, size_t size, burst_e burst,
                                              int unsigned count);
  int unsigned nbytes;
  nbytes = 1 << size;
  if (burst == FIXED || count == 0) begin
    return base % (1 << AddrWidth);
  end
  return ((base / nbytes) * nbytes + count * nbytes) % (1 << AddrWidth);
endfunction

// WRAP bursts and beats past the end of memory are rejected
function automatic bit beat_in_range(int unsigned addr, burst_e burst);
  return (addr < MemBytes) && (burst != WRAP);
endfunction

function automatic resp_e beat_resp(bit ok);
  return ok ? OKAY : SLVERR;
endfunction

// Strobes apply to the whole bus word, regardless of size
function automatic void store_beat(int unsigned addr, logic [DataWidth-1:0] data,
                                   logic [StrbWidth-1:0] strb);
  int unsigned word_base;
  word_base = addr - (addr % StrbWidth);
  for (int b = 0; b < StrbWidth; b++) begin
    if (strb[b]) begin
      model_mem[word_base + b] = data[b*8 +: 8];
    end
  end
endfunction

// Rejected beats read as zero
function automatic logic [DataWidth-1:0] load_beat(int unsigned addr, bit ok);
  logic [DataWidth-1:0] word;
  int unsigned          word_base;
  word      = '0;
  word_base = addr - (addr % StrbWidth);
  if (ok) begin
    for (int b = 0; b < StrbWidth; b++) begin
      word[b*8 +: 8] = model_mem[word_base + b];
    end
  end
  return word;
endfunction

`endif

// File: testbench/tb_axi_mem_top.sv
/*
 * Testbench for the AXI4 slave memory
 * Random write and read bursts with back-pressure, checked against a
 * byte-level reference memory, plus beat-by-beat monitor checks.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_top;

  import axi_pkg::*;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned MemBytes  = 1024;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned DirectedOps  = 8;
  localparam int unsigned RandomOps    = 192;
  localparam int unsigned MaxCycles = (DirectedOps + RandomOps) * 260 * 4;

  typedef struct packed {
    logic [31:0]          cyc;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
    logic [IdWidth-1:0]   id;
    len_t                 cnt;
    logic                 last;
  } mon_beat_t;

  logic                 clk_i = 1'b0;
  logic                 rst_i;
  logic                 aw_valid_i;
  logic                 aw_ready_o;
  logic [IdWidth-1:0]   aw_id_i;
  logic [AddrWidth-1:0] aw_addr_i;
  len_t                 aw_len_i;
  size_t                aw_size_i;
  burst_e               aw_burst_i;
  logic                 w_valid_i;
  logic                 w_ready_o;
  logic [DataWidth-1:0] w_data_i;
  logic [StrbWidth-1:0] w_strb_i;
  logic                 w_last_i;
  logic                 b_valid_o;
  logic                 b_ready_i;
  logic [IdWidth-1:0]   b_id_o;
  resp_e                b_resp_o;
  logic                 ar_valid_i;
  logic                 ar_ready_o;
  logic [IdWidth-1:0]   ar_id_i;
  logic [AddrWidth-1:0] ar_addr_i;
  len_t                 ar_len_i;
  size_t                ar_size_i;
  burst_e               ar_burst_i;
  logic                 r_valid_o;
  logic                 r_ready_i;
  logic [IdWidth-1:0]   r_id_o;
  logic [DataWidth-1:0] r_data_o;
  resp_e                r_resp_o;
  logic                 r_last_o;
  logic                 mon_w_valid_o;
  logic [AddrWidth-1:0] mon_w_addr_o;
  logic [DataWidth-1:0] mon_w_data_o;
  logic [IdWidth-1:0]   mon_w_id_o;
  len_t                 mon_w_beat_count_o;
  logic                 mon_w_last_o;
  logic                 mon_r_valid_o;
  logic [AddrWidth-1:0] mon_r_addr_o;
  logic [DataWidth-1:0] mon_r_data_o;
  logic [IdWidth-1:0]   mon_r_id_o;
  len_t                 mon_r_beat_count_o;
  logic                 mon_r_last_o;

  integer      seed;
  string       test_name;
  int unsigned cycles = 0;
  mon_beat_t   wmon_q[$];
  mon_beat_t   rmon_q[$];

  `include "tb_mem_model.svh"

  axi_mem_top #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .IdWidth   (IdWidth),
    .MemBytes  (MemBytes)
  ) dut (
    .clk_i (clk_i), .rst_i (rst_i),
    .aw_valid_i (aw_valid_i), .aw_ready_o (aw_ready_o), .aw_id_i (aw_id_i),
    .aw_addr_i (aw_addr_i), .aw_len_i (aw_len_i), .aw_size_i (aw_size_i),
    .aw_burst_i (aw_burst_i),
    .w_valid_i (w_valid_i), .w_ready_o (w_ready_o), .w_data_i (w_data_i),
    .w_strb_i (w_strb_i), .w_last_i (w_last_i),
    .b_valid_o (b_valid_o), .b_ready_i (b_ready_i), .b_id_o (b_id_o), .b_resp_o (b_resp_o),
    .ar_valid_i (ar_valid_i), .ar_ready_o (ar_ready_o), .ar_id_i (ar_id_i),
    .ar_addr_i (ar_addr_i), .ar_len_i (ar_len_i), .ar_size_i (ar_size_i),
    .ar_burst_i (ar_burst_i),
    .r_valid_o (r_valid_o), .r_ready_i (r_ready_i), .r_id_o (r_id_o), .r_data_o (r_data_o),
    .r_resp_o (r_resp_o), .r_last_o (r_last_o),
    .mon_w_valid_o (mon_w_valid_o), .mon_w_addr_o (mon_w_addr_o),
    .mon_w_data_o (mon_w_data_o), .mon_w_id_o (mon_w_id_o),
    .mon_w_beat_count_o (mon_w_beat_count_o), .mon_w_last_o (mon_w_last_o),
    .mon_r_valid_o (mon_r_valid_o), .mon_r_addr_o (mon_r_addr_o),
    .mon_r_data_o (mon_r_data_o), .mon_r_id_o (mon_r_id_o),
    .mon_r_beat_count_o (mon_r_beat_count_o), .mon_r_last_o (mon_r_last_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_resp(string what, resp_e exp, resp_e act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s %s: expected %s, actual %s", test_name, what,
                          exp.name(), act.name()));
    end
  endtask

  task automatic check_data(string what, logic [DataWidth-1:0] exp, logic [DataWidth-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_id(string what, logic [IdWidth-1:0] exp, logic [IdWidth-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      abort_run($sformatf("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_beat(string what, len_t exp_cnt, len_t act_cnt,
                            logic [AddrWidth-1:0] exp_addr, logic [AddrWidth-1:0] act_addr);
    if (exp_cnt !== act_cnt || exp_addr !== act_addr) begin
      abort_run($sformatf("ERROR %s %s: expected beat %0d addr %h, actual beat %0d addr %h",
                          test_name, what, exp_cnt, exp_addr, act_cnt, act_addr));
    end
  endtask

  function automatic mon_beat_t make_beat(int unsigned cyc, int unsigned addr,
                                          logic [DataWidth-1:0] data, logic [IdWidth-1:0] id,
                                          int unsigned cnt, logic last);
    mon_beat_t beat;
    beat.cyc  = cyc;
    beat.addr = addr[AddrWidth-1:0];
    beat.data = data;
    beat.id   = id;
    beat.cnt  = len_t'(cnt);
    beat.last = last;
    return beat;
  endfunction

  task automatic compare_monitor(string what, mon_beat_t exp, mon_beat_t act);
    check_beat({what, " beat"}, exp.cnt, act.cnt, exp.addr, act.addr);
    check_data({what, " data"}, exp.data, act.data);
    check_id({what, " id"}, exp.id, act.id);
    check_flag({what, " last"}, exp.last, act.last);
  endtask

  task automatic check_idle_outputs();
    check_flag("b_valid_o", 1'b0, b_valid_o);
    check_flag("r_valid_o", 1'b0, r_valid_o);
    check_flag("mon_w_valid_o", 1'b0, mon_w_valid_o);
    check_flag("mon_r_valid_o", 1'b0, mon_r_valid_o);
  endtask

  task automatic check_ready_outputs(logic aw_exp, logic w_exp, logic ar_exp);
    check_flag("aw_ready_o", aw_exp, aw_ready_o);
    check_flag("w_ready_o", w_exp, w_ready_o);
    check_flag("ar_ready_o", ar_exp, ar_ready_o);
  endtask

  task automatic write_burst(logic [IdWidth-1:0] id, int unsigned addr, len_t len, size_t size,
                             burst_e burst, bit full_strb);
    int unsigned          a;
    bit                   err;
    bit                   done;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    err        = 1'b0;
    done       = 1'b0;
    b_ready_i  = 1'b0;
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr[AddrWidth-1:0];
    aw_len_i   = len;
    aw_size_i  = size;
    aw_burst_i = burst;
    while (!aw_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      a         = expected_addr(addr, size, burst, beat);
      data      = $random(seed);
      strb      = full_strb ? '1 : StrbWidth'($random(seed));
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (beat == int'(len));
      while (!w_ready_o) @(negedge clk_i);
      // Transfer happens at the coming rising edge
      if (beat_in_range(a, burst)) begin
        store_beat(a, data, strb);
      end else begin
        err = 1'b1;
      end
      wmon_q.push_back(make_beat(cycles + 1, a, data, id, beat, beat == int'(len)));
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    while (!done) begin
      b_ready_i = (($random(seed) & 3) != 0);
      // No new burst is accepted while B is pending
      check_ready_outputs(1'b0, 1'b0, 1'b1);
      if (b_valid_o) begin
        check_id("b_id_o", id, b_id_o);
        check_resp("b_resp_o", beat_resp(!err), b_resp_o);
        done = b_ready_i;
      end
      @(negedge clk_i);
    end
    b_ready_i = 1'b0;
  endtask

  task automatic read_burst(logic [IdWidth-1:0] id, int unsigned addr, len_t len, size_t size,
                            burst_e burst);
    int unsigned          a;
    int unsigned          beat;
    bit                   ok;
    logic [DataWidth-1:0] data;
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr[AddrWidth-1:0];
    ar_len_i   = len;
    ar_size_i  = size;
    ar_burst_i = burst;
    while (!ar_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    beat       = 0;
    while (beat <= len) begin
      r_ready_i = (($random(seed) & 3) != 0);
      check_ready_outputs(1'b1, 1'b0, 1'b0);
      // Payload is checked on every cycle it is valid, so it must hold under back-pressure
      if (r_valid_o) begin
        a    = expected_addr(addr, size, burst, beat);
        ok   = beat_in_range(a, burst);
        data = load_beat(a, ok);
        check_data("r_data_o", data, r_data_o);
        check_resp("r_resp_o", beat_resp(ok), r_resp_o);
        check_id("r_id_o", id, r_id_o);
        check_flag("r_last_o", beat == len, r_last_o);
        if (r_ready_i) begin
          rmon_q.push_back(make_beat(cycles + 1, a, data, id, beat, beat == len));
          beat++;
        end
      end
      @(negedge clk_i);
    end
    r_ready_i = 1'b0;
  endtask

  task automatic random_op();
    logic [IdWidth-1:0] id;
    int unsigned        addr;
    len_t               len;
    size_t              size;
    burst_e             burst;
    int unsigned        pick;
    id    = IdWidth'($random(seed));
    addr  = $unsigned($random(seed)) % (MemBytes + 256);
    len   = (($random(seed) & 7) == 0) ? len_t'($random(seed)) : len_t'($random(seed) & 15);
    size  = size_t'($unsigned($random(seed)) % 3);
    pick  = $unsigned($random(seed)) % 8;
    burst = (pick == 0) ? WRAP : ((pick < 3) ? FIXED : INCR);
    if ($random(seed) & 1) begin
      write_burst(id, addr, len, size, burst, ($random(seed) & 3) == 0);
    end else begin
      read_burst(id, addr, len, size, burst);
    end
  endtask

  // Cycle count for monitor timing and the run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", MaxCycles));
    end
  end

  always @(negedge clk_i) begin
    if (mon_w_valid_o === 1'b1) begin
      if (wmon_q.size() == 0 || wmon_q[0].cyc != cycles) begin
        abort_run("Write monitor pulsed without a W transfer in the cycle before");
      end
      compare_monitor("write monitor", wmon_q.pop_front(),
                      make_beat(cycles, mon_w_addr_o, mon_w_data_o, mon_w_id_o,
                                mon_w_beat_count_o, mon_w_last_o));
    end else if (wmon_q.size() != 0 && wmon_q[0].cyc <= cycles) begin
      abort_run("Write monitor gave no pulse one cycle after a W transfer");
    end
  end

  always @(negedge clk_i) begin
    if (mon_r_valid_o === 1'b1) begin
      if (rmon_q.size() == 0 || rmon_q[0].cyc != cycles) begin
        abort_run("Read monitor pulsed without an R transfer in the cycle before");
      end
      compare_monitor("read monitor", rmon_q.pop_front(),
                      make_beat(cycles, mon_r_addr_o, mon_r_data_o, mon_r_id_o,
                                mon_r_beat_count_o, mon_r_last_o));
    end else if (rmon_q.size() != 0 && rmon_q[0].cyc <= cycles) begin
      abort_run("Read monitor gave no pulse one cycle after an R transfer");
    end
  end

  initial begin
    seed       = 46344;
    test_name  = "reset";
    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_size_i  = '0;
    aw_burst_i = INCR;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_size_i  = '0;
    ar_burst_i = INCR;
    r_ready_i  = 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      check_idle_outputs();
      check_ready_outputs(1'b0, 1'b0, 1'b0);
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    check_idle_outputs();
    // Address channels open in the first cycle after reset
    check_ready_outputs(1'b1, 1'b0, 1'b1);

    // Whole memory gets defined contents first
    test_name = "fill";
    write_burst(4'h1, 0, 8'd255, 3'd2, INCR, 1'b1);
    test_name = "readback";
    read_burst(4'h2, 0, 8'd255, 3'd2, INCR);
    test_name = "fixed";
    write_burst(4'h3, 16'h40, 8'd7, 3'd2, FIXED, 1'b1);
    read_burst(4'h4, 16'h40, 8'd3, 3'd2, FIXED);
    test_name = "wrap";
    write_burst(4'h5, 16'h80, 8'd3, 3'd2, WRAP, 1'b1);
    read_burst(4'h6, 16'h80, 8'd3, 3'd2, WRAP);
    test_name = "end_of_memory";
    write_burst(4'h7, MemBytes - 16, 8'd7, 3'd2, INCR, 1'b1);
    read_burst(4'h8, MemBytes - 16, 8'd7, 3'd2, INCR);

    test_name = "random";
    repeat (RandomOps) begin
      random_op();
    end

    // Let the last monitor pulse be checked
    repeat (2) @(negedge clk_i);
    if (wmon_q.size() != 0 || rmon_q.size() != 0) begin
      $display("Monitor pulses still outstanding at the end of the run");
      $display("Test failures found");
      $fatal(1);
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: axi_mem_top.f
+incdir+testbench
rtl/axi_pkg.sv
rtl/mem_ctrl_pkg.sv
rtl/mem_byte_array.sv
rtl/axi_mem_wr_ctrl.sv
rtl/axi_mem_rd_ctrl.sv
rtl/axi_mem_top.sv
testbench/tb_axi_mem_top.sv

// File: Bender.yml
package:
  name: axi_mem_top

sources:
  - rtl/axi_pkg.sv
  - rtl/mem_ctrl_pkg.sv
  - rtl/mem_byte_array.sv
  - rtl/axi_mem_wr_ctrl.sv
  - rtl/axi_mem_rd_ctrl.sv
  - rtl/axi_mem_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_axi_mem_top.sv
